// File: include/l1_miss_macros.svh
/*
 * Sizing for the L1 miss tracking unit.
 * L1_THREADS is both the thread count and the entry count, and must be 2 or more.
 * L1_LINE_ADDR_WIDTH is the byte address width minus the line offset bits.
 */

`ifndef L1_MISS_MACROS_SVH
`define L1_MISS_MACROS_SVH

// Hardware threads per core, one miss entry each
`define L1_THREADS 4

// Line address width, 32 bit byte address with 64 byte lines
`define L1_LINE_ADDR_WIDTH 26

`endif

// File: verilog/l1_miss_pkg.sv
/*
 * Types shared by the L1 miss tracking unit.
 * Widths come from l1_miss_macros.svh, which must be on the include path.
 */

`include "l1_miss_macros.svh"

package l1_miss_pkg;

	// Cache line address, byte offset stripped
	typedef logic [`L1_LINE_ADDR_WIDTH - 1:0] line_addr_t;

	// Thread index, also used as entry index
	typedef logic [$clog2(`L1_THREADS) - 1:0] thread_idx_t;

	// One bit per thread
	typedef logic [`L1_THREADS - 1:0] thread_mask_t;

	// Life of a miss entry
	typedef enum logic [1:0]
	{
		ENTRY_IDLE = 2'd0,
		ENTRY_PENDING = 2'd1,
		ENTRY_SENT = 2'd2
	} entry_state_t;

	// One tracked miss
	typedef struct packed
	{
		entry_state_t state;
		thread_mask_t waiting;
		line_addr_t address;
		logic synchronized;
	} miss_entry_t;

	// Miss from the cache tag stage
	typedef struct packed
	{
		line_addr_t address;
		thread_idx_t thread_idx;
		logic synchronized;
	} miss_req_t;

	// Fill request toward memory
	typedef struct packed
	{
		line_addr_t address;
		thread_idx_t entry_idx;
	} fill_req_t;

endpackage

// File: verilog/miss_match.sv
/*
 * Decodes an incoming miss against the entry table, purely combinational.
 * Synchronized misses never merge, in either direction.
 * collided_oh is not qualified by cache_miss; consumers must gate it.
 */

`timescale 1ns/1ps

`include "l1_miss_macros.svh"

module miss_match
	import l1_miss_pkg::*;
(
	// Incoming miss
	input  miss_req_t    miss_req,
	input  logic         cache_miss,

	// Current table image
	input  miss_entry_t  entries[`L1_THREADS],

	// Decoded results
	output thread_mask_t miss_thread_oh,
	output thread_mask_t collided_oh,
	output logic         alloc
);

	logic any_collision;

	for (genvar i = 0; i < `L1_THREADS; i++)
	begin : gen_match
		logic entry_live;
		logic addr_equal;
		logic can_merge;

		// Thread index to one-hot
		assign miss_thread_oh[i] = miss_req.thread_idx == thread_idx_t'(i);

		// Entry holds a miss, pending or already sent
		assign entry_live = entries[i].state != ENTRY_IDLE;

		// Same cache line
		assign addr_equal = entries[i].address == miss_req.address;

		// Merge only when neither side is synchronized
		assign can_merge = !entries[i].synchronized && !miss_req.synchronized;

		assign collided_oh[i] = entry_live && addr_equal && can_merge;
	end

	// Any entry already waiting on this line
	assign any_collision = |collided_oh;

	// New entry only when nothing can absorb the miss
	assign alloc = cache_miss && !any_collision;

endmodule

// File: verilog/miss_entry_table.sv
/*
 * Entry state for the L1 miss tracking unit, one entry per thread.
 * Caller keeps the rules: a thread misses only with its entry idle and not
 * waiting elsewhere, a wake never names an idle entry, and a wake and a miss
 * never touch the same entry in one cycle.
 */

`timescale 1ns/1ps

`include "l1_miss_macros.svh"

module miss_entry_table
	import l1_miss_pkg::*;
(
	input  logic         clk,
	input  logic         reset,

	// Decoded miss
	input  miss_req_t    miss_req,
	input  thread_mask_t miss_thread_oh,
	input  thread_mask_t collided_oh,
	input  logic         alloc,
	input  logic         cache_miss,

	// Fill request handshake
	input  logic         dequeue_ack,
	input  thread_mask_t grant_oh,
	input  thread_idx_t  grant_idx,

	// Fill returned
	input  logic         wake_en,
	input  thread_idx_t  wake_idx,

	// Table image for the matcher
	output miss_entry_t  entries[`L1_THREADS],

	// Entries still to be sent
	output thread_mask_t pending_oh,

	output logic         dequeue_ready,
	output fill_req_t    dequeue_req,
	output thread_mask_t wake_oh
);

	for (genvar i = 0; i < `L1_THREADS; i++)
	begin : gen_entry
		entry_state_t state;
		thread_mask_t waiting;
		line_addr_t address;
		logic synchronized;
		logic ack_hit;
		logic alloc_hit;
		logic wake_hit;
		logic merge_hit;

		// Fill request for this entry accepted
		assign ack_hit = dequeue_ack && grant_oh[i];

		// New miss lands in the issuing thread's own entry
		assign alloc_hit = alloc && miss_thread_oh[i];

		assign wake_hit = wake_en && wake_idx == thread_idx_t'(i);

		// Another thread joins this entry
		assign merge_hit = cache_miss && collided_oh[i];

		// Priority per entry is ack, then allocate, then free
		always_ff @(posedge clk, posedge reset)
		begin
			if (reset)
			begin
				state <= ENTRY_IDLE;
				waiting <= '0;
			end
			else
			begin
				if (ack_hit)
					state <= ENTRY_SENT;
				else if (alloc_hit)
				begin
					state <= ENTRY_PENDING;
					waiting <= miss_thread_oh;
				end
				else if (wake_hit)
					state <= ENTRY_IDLE;

				// Merge rides on top, may coincide with an ack
				if (merge_hit)
					waiting <= waiting | miss_thread_oh;
			end
		end

		// Line address and sync flag captured once per allocation
		always_ff @(posedge clk)
		begin
			if (alloc_hit)
			begin
				address <= miss_req.address;
				synchronized <= miss_req.synchronized;
			end
		end

		assign pending_oh[i] = state == ENTRY_PENDING;

		assign entries[i].state = state;
		assign entries[i].waiting = waiting;
		assign entries[i].address = address;
		assign entries[i].synchronized = synchronized;
	end

	// Something left to send
	assign dequeue_ready = |pending_oh;

	// Granted entry goes out, held until acked
	assign dequeue_req.address = entries[grant_idx].address;
	assign dequeue_req.entry_idx = grant_idx;

	// Threads to release on this fill
	assign wake_oh = wake_en ? entries[wake_idx].waiting : '0;

endmodule

// File: verilog/send_arbiter.sv
/*
 * Round-robin pick among pending entries, grant follows request combinationally.
 * A refused grant is held until accepted, a later request cannot take its place.
 * Pointer only moves on an accepted grant. Entry count need not be a power of two.
 */

`timescale 1ns/1ps

`include "l1_miss_macros.svh"

module send_arbiter
	import l1_miss_pkg::*;
(
	input  logic         clk,
	input  logic         reset,

	// Entries wanting service
	input  thread_mask_t request,

	// Grant accepted this cycle
	input  logic         advance,

	output thread_mask_t grant_oh,
	output thread_idx_t  grant_idx
);

	// First entry to look at
	thread_idx_t ptr;

	// Grant shown and refused, kept until accepted
	thread_mask_t held_oh;

	// Held grant wins, else search from ptr upward with wrap, first hit wins
	always_comb
	begin
		int idx;
		logic found;

		grant_oh = held_oh & request;
		found = |grant_oh;
		for (int off = 0; off < `L1_THREADS; off++)
		begin
			idx = (int'(ptr) + off) % `L1_THREADS;
			if (!found && request[idx])
			begin
				grant_oh[idx] = 1'b1;
				found = 1'b1;
			end
		end
	end

	// One-hot to index
	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < `L1_THREADS; i++)
		begin
			if (grant_oh[i])
				grant_idx = grant_idx | thread_idx_t'(i);
		end
	end

	// Remember a grant that was on show and not taken
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			held_oh <= '0;
		else if (advance)
			held_oh <= '0;
		else
			held_oh <= grant_oh;
	end

	// Next search starts just past the winner
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			ptr <= '0;
		else if (advance && |request)
		begin
			if (grant_idx == thread_idx_t'(`L1_THREADS - 1))
				ptr <= '0;
			else
				ptr <= grant_idx + 1'b1;
		end
	end

endmodule

// File: verilog/l1_miss_unit.sv
/*
 * L1 data cache miss tracking unit, one entry per hardware thread.
 * Miss to dequeue_ready is 1 cycle, wake_en to wake_oh is 0 cycles.
 * dequeue_ack is only legal while dequeue_ready is high.
 */

`timescale 1ns/1ps

`include "l1_miss_macros.svh"

module l1_miss_unit
	import l1_miss_pkg::*;
(
	input  logic         clk,
	input  logic         reset,

	// Miss from the cache tag stage
	input  logic         cache_miss,
	input  miss_req_t    cache_miss_req,

	// Fill request out
	output logic         dequeue_ready,
	input  logic         dequeue_ack,
	output fill_req_t    dequeue_req,

	// Fill returned, threads to wake
	input  logic         wake_en,
	input  thread_idx_t  wake_idx,
	output thread_mask_t wake_oh
);

	miss_entry_t entries[`L1_THREADS];
	thread_mask_t miss_thread_oh;
	thread_mask_t collided_oh;
	logic alloc;
	thread_mask_t pending_oh;
	thread_mask_t grant_oh;
	thread_idx_t grant_idx;

	// Collision check and allocate decision
	miss_match u_match (
		.miss_req       (cache_miss_req),
		.cache_miss     (cache_miss),
		.entries        (entries),
		.miss_thread_oh (miss_thread_oh),
		.collided_oh    (collided_oh),
		.alloc          (alloc)
	);

	// Entry registers, fill request and wake read
	miss_entry_table u_table (
		.clk            (clk),
		.reset          (reset),
		.miss_req       (cache_miss_req),
		.miss_thread_oh (miss_thread_oh),
		.collided_oh    (collided_oh),
		.alloc          (alloc),
		.cache_miss     (cache_miss),
		.dequeue_ack    (dequeue_ack),
		.grant_oh       (grant_oh),
		.grant_idx      (grant_idx),
		.wake_en        (wake_en),
		.wake_idx       (wake_idx),
		.entries        (entries),
		.pending_oh     (pending_oh),
		.dequeue_ready  (dequeue_ready),
		.dequeue_req    (dequeue_req),
		.wake_oh        (wake_oh)
	);

	// Picks which pending entry is offered
	send_arbiter u_arbiter (
		.clk       (clk),
		.reset     (reset),
		.request   (pending_oh),
		.advance   (dequeue_ack),
		.grant_oh  (grant_oh),
		.grant_idx (grant_idx)
	);

endmodule

// File: dv/l1_miss_unit_sva.sv
/*
 * Usage and output rules of l1_miss_unit, bound into every instance.
 * All checks are off while reset is high.
 */

`timescale 1ns/1ps

module l1_miss_unit_sva
	import l1_miss_pkg::*;
(
	input logic         clk,
	input logic         reset,
	input logic         dequeue_ready,
	input logic         dequeue_ack,
	input fill_req_t    dequeue_req,
	input logic         wake_en,
	input thread_mask_t wake_oh
);

	// Ack only answers a request on show
	ack_needs_ready: assert property (@(posedge clk) disable iff (reset)
		dequeue_ack |-> dequeue_ready)
	else
		$error("dequeue_ack seen while dequeue_ready is low");

	// No wake outside a fill
	wake_quiet: assert property (@(posedge clk) disable iff (reset)
		!wake_en |-> wake_oh == '0)
	else
		$error("wake_oh nonzero without wake_en");

	// Refused request stays on show unchanged
	req_held: assert property (@(posedge clk) disable iff (reset)
		dequeue_ready && !dequeue_ack |=> dequeue_ready && $stable(dequeue_req))
	else
		$error("dequeue_req changed while held without ack");

	// Every fill wakes at least its owner
	wake_someone: assert property (@(posedge clk) disable iff (reset)
		wake_en |-> wake_oh != '0)
	else
		$error("wake_en with an empty wake_oh");

endmodule

bind l1_miss_unit l1_miss_unit_sva u_sva (
	.clk           (clk),
	.reset         (reset),
	.dequeue_ready (dequeue_ready),
	.dequeue_ack   (dequeue_ack),
	.dequeue_req   (dequeue_req),
	.wake_en       (wake_en),
	.wake_oh       (wake_oh)
);

// File: dv/l1_miss_unit_tb.sv
/*
 * Table-driven testbench for l1_miss_unit, built for the default sizing of 4 threads.
 * Inputs change on the falling edge, outputs are sampled 1 ns before the rising edge.
 * Rows keep the usage rules, expected values are worked out by hand per row.
 */

`timescale 1ns/1ps

module l1_miss_unit_tb
	import l1_miss_pkg::*;
();

	localparam int RESET_CYCLES = 2;

	// Line addresses used by the rows
	localparam line_addr_t ADDR_A = 26'h0abc123;
	localparam line_addr_t ADDR_B = 26'h1234567;
	localparam line_addr_t ADDR_C = 26'h0ff00ff;
	localparam line_addr_t ADDR_D = 26'h3c0ffee;

	// What a row does in its cycle
	typedef enum logic [2:0]
	{
		ACT_IDLE,
		ACT_MISS,
		ACT_ACK,
		ACT_WAKE,
		ACT_MISS_ACK
	} action_t;

	// One cycle of stimulus and its expected outputs
	typedef struct packed
	{
		action_t act;
		thread_idx_t thread;
		line_addr_t address;
		logic sync;
		thread_idx_t wake;
		logic exp_ready;
		fill_req_t exp_fill;
		thread_mask_t exp_wake;
	} row_t;

	logic clk;
	logic reset;
	logic cache_miss;
	miss_req_t cache_miss_req;
	logic dequeue_ready;
	logic dequeue_ack;
	fill_req_t dequeue_req;
	logic wake_en;
	thread_idx_t wake_idx;
	thread_mask_t wake_oh;

	row_t rows[$];
	int cycle_count = 0;
	int cycle_limit = 1000;

	l1_miss_unit uut (
		.clk            (clk),
		.reset          (reset),
		.cache_miss     (cache_miss),
		.cache_miss_req (cache_miss_req),
		.dequeue_ready  (dequeue_ready),
		.dequeue_ack    (dequeue_ack),
		.dequeue_req    (dequeue_req),
		.wake_en        (wake_en),
		.wake_idx       (wake_idx),
		.wake_oh        (wake_oh)
	);

	// 10 ns clock
	always #5 clk = ~clk;

	// Print the reason, then the fail line, then stop
	task automatic stop_on_error(input string what);
		$display("%s", what);
		$display("Errors found");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_ready(input logic expected, input logic actual);
		if (actual !== expected)
			stop_on_error($sformatf("error at %0t: dequeue_ready expected %b, got %b",
				$time, expected, actual));
	endtask

	task automatic check_fill(input fill_req_t expected, input fill_req_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("error at %0t: dequeue_req expected %h/%0d, got %h/%0d",
				$time, expected.address, expected.entry_idx, actual.address, actual.entry_idx));
	endtask

	task automatic check_wake(input thread_mask_t expected, input thread_mask_t actual);
		if (actual !== expected)
			stop_on_error($sformatf("error at %0t: wake_oh expected %b, got %b",
				$time, expected, actual));
	endtask

	// Append one row to the table
	task automatic put_row(input action_t act, input int thread, input line_addr_t addr,
		input logic sync, input int widx, input logic rdy, input line_addr_t faddr,
		input int fidx, input thread_mask_t wmask);
		row_t r;
		r.act = act;
		r.thread = thread_idx_t'(thread);
		r.address = addr;
		r.sync = sync;
		r.wake = thread_idx_t'(widx);
		r.exp_ready = rdy;
		r.exp_fill.address = faddr;
		r.exp_fill.entry_idx = thread_idx_t'(fidx);
		r.exp_wake = wmask;
		rows.push_back(r);
	endtask

	// Columns: action, thread, address, sync, wake idx, ready, fill addr, fill idx, wake mask
	task automatic load_table();
		// Quiet after reset
		put_row(ACT_IDLE, 0, '0, 0, 0, 0, '0, 0, 4'b0000);
		// Thread 2 misses, request shows one cycle later and is held
		put_row(ACT_MISS, 2, ADDR_A, 0, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 1, ADDR_A, 2, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 1, ADDR_A, 2, 4'b0000);
		// Thread 0 merges into entry 2 under back-pressure
		put_row(ACT_MISS, 0, ADDR_A, 0, 0, 1, ADDR_A, 2, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 1, ADDR_A, 2, 4'b0000);
		put_row(ACT_ACK, 0, '0, 0, 0, 1, ADDR_A, 2, 4'b0000);
		// Synchronized miss on the same line gets its own entry
		put_row(ACT_MISS, 1, ADDR_A, 1, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 1, ADDR_A, 1, 4'b0000);
		put_row(ACT_ACK, 0, '0, 0, 0, 1, ADDR_A, 1, 4'b0000);
		// Merged wake, then the synchronized one alone
		put_row(ACT_WAKE, 0, '0, 0, 2, 0, '0, 0, 4'b0101);
		put_row(ACT_WAKE, 0, '0, 0, 1, 0, '0, 0, 4'b0010);
		// Fill entries 0, 1 and 3 with the pointer at 2
		put_row(ACT_MISS, 0, ADDR_B, 0, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_MISS, 1, ADDR_C, 0, 0, 1, ADDR_B, 0, 4'b0000);
		put_row(ACT_MISS, 3, ADDR_D, 0, 0, 1, ADDR_B, 0, 4'b0000);
		// Entry 0 keeps its grant, then round-robin from 1 gives 1, 3
		put_row(ACT_ACK, 0, '0, 0, 0, 1, ADDR_B, 0, 4'b0000);
		put_row(ACT_ACK, 0, '0, 0, 0, 1, ADDR_C, 1, 4'b0000);
		put_row(ACT_ACK, 0, '0, 0, 0, 1, ADDR_D, 3, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_WAKE, 0, '0, 0, 3, 0, '0, 0, 4'b1000);
		put_row(ACT_WAKE, 0, '0, 0, 0, 0, '0, 0, 4'b0001);
		put_row(ACT_WAKE, 0, '0, 0, 1, 0, '0, 0, 4'b0010);
		// Same thread and line allocate again after the wake
		put_row(ACT_MISS, 2, ADDR_A, 0, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 1, ADDR_A, 2, 4'b0000);
		// Merge lands in the same edge as the ack
		put_row(ACT_MISS_ACK, 3, ADDR_A, 0, 0, 1, ADDR_A, 2, 4'b0000);
		// Thread 0 joins the entry after its request went out
		put_row(ACT_MISS, 0, ADDR_A, 0, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_IDLE, 0, '0, 0, 0, 0, '0, 0, 4'b0000);
		put_row(ACT_WAKE, 0, '0, 0, 2, 0, '0, 0, 4'b1101);
		put_row(ACT_IDLE, 0, '0, 0, 0, 0, '0, 0, 4'b0000);
	endtask

	// Turn a row's action into input strobes
	task automatic drive_row(input row_t r);
		cache_miss = (r.act == ACT_MISS) || (r.act == ACT_MISS_ACK);
		dequeue_ack = (r.act == ACT_ACK) || (r.act == ACT_MISS_ACK);
		wake_en = r.act == ACT_WAKE;
		cache_miss_req.address = r.address;
		cache_miss_req.thread_idx = r.thread;
		cache_miss_req.synchronized = r.sync;
		wake_idx = r.wake;
	endtask

	task automatic check_row(input row_t r);
		check_ready(r.exp_ready, dequeue_ready);
		// Payload is a don't care while nothing is offered
		if (r.exp_ready)
			check_fill(r.exp_fill, dequeue_req);
		check_wake(r.exp_wake, wake_oh);
	endtask

	// Run limit
	always @(posedge clk)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
			stop_on_error($sformatf("timeout: run went past %0d cycles", cycle_limit));
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		cache_miss = 1'b0;
		cache_miss_req = '0;
		dequeue_ack = 1'b0;
		wake_en = 1'b0;
		wake_idx = '0;
		load_table();
		cycle_limit = rows.size() + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < rows.size(); i++)
		begin
			@(negedge clk);
			drive_row(rows[i]);
			// Just before the rising edge
			#4;
			check_row(rows[i]);
		end

		@(negedge clk);
		cache_miss = 1'b0;
		dequeue_ack = 1'b0;
		wake_en = 1'b0;

		$display("No errors");
		$finish;
	end

endmodule

// File: l1_miss_unit.f
+incdir+include
verilog/l1_miss_pkg.sv
verilog/miss_match.sv
verilog/miss_entry_table.sv
verilog/send_arbiter.sv
verilog/l1_miss_unit.sv
dv/l1_miss_unit_sva.sv
dv/l1_miss_unit_tb.sv

// File: Makefile
# Verilator build and run for the L1 miss tracking unit
# Any variable can be overridden, e.g. make run LOG=run1.log

VERILATOR ?= verilator
TOP       ?= l1_miss_unit_tb
FILELIST  ?= l1_miss_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= Errors found
PASS_MSG  ?= No errors

BIN     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(FILELIST) $(wildcard verilog/*.sv) $(wildcard dv/*.sv) $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# A fail line in the log, or no pass line at all, fails the run
run: compile
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "FAIL: see $(LOG)"; exit 1; \
	elif ! grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "FAIL: run ended early, see $(LOG)"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
